//--- files.f
hw/musicBoxPkg.sv
hw/songSelect.sv
hw/songRom.sv
hw/noteSequencer.sv
hw/pitchTable.sv
hw/musicBoxTop.sv
sim/musicBox_props.sv
sim/musicBoxChecker.sv
sim/musicBoxTb.sv

//--- hw/musicBoxPkg.sv
/*
 * music box shared definitions
 * widths, song choice and pitch codes used across the player
 */
package musicBoxPkg;

    // 5-bit pitch code, 8 is the rest
    typedef logic [4:0] pitchCode;
    // duration code, carried through untouched
    typedef logic [1:0] noteDuration;
    // half-period of the tone in playSound cycles
    typedef logic [19:0] notePeriod;
    // address into a song table
    typedef logic [5:0] songAddr;
    // {play, pitch[4:0], duration[1:0]}
    typedef logic [7:0] songEntry;

    typedef enum logic [1:0] {
        songNone,
        songJas,
        songMcDonald
    } songChoice;

    //////////////////////////////
    // fixed codes and addresses
    //////////////////////////////

    localparam pitchCode restCode = 5'd8;
    // address 0 is the idle slot, melodies start here
    localparam songAddr firstNote = 6'd1;

    // octave boundaries of the pitch code space
    localparam pitchCode pitchC3 = 5'd0;
    localparam pitchCode pitchB3 = 5'd6;
    localparam pitchCode pitchC4 = 5'd9;
    localparam pitchCode pitchB4 = 5'd15;
    localparam pitchCode pitchC5 = 5'd16;
    localparam pitchCode pitchC6 = 5'd23;

    // named notes used by the melodies
    localparam pitchCode pitchE4 = 5'd11;
    localparam pitchCode pitchG4 = 5'd13;
    localparam pitchCode pitchA4 = 5'd14;
    localparam pitchCode pitchD5 = 5'd17;
    localparam pitchCode pitchE5 = 5'd18;

endpackage

//--- hw/musicBoxTop.sv
/*
 * music box top
 * song select, melody ROM, sequencer and pitch lookup
 */
`timescale 1ns/100ps

module musicBoxTop
    import musicBoxPkg::*;
#(
    // playSound frequency
    parameter int clockHz = 100_000_000
) (
    input  logic        playSound,
    input  logic        start,
    input  logic        song3,
    input  logic        song4,
    output notePeriod   note,
    output noteDuration duration,
    output songAddr     memLoc,
    output pitchCode    notecase
);

    // held song choice
    songChoice choice;
    // current table entry
    songEntry  entry;

    //////////////////////////////
    // input side
    //////////////////////////////

    songSelect uSongSelect (
        .playSound (playSound),
        .song3     (song3),
        .song4     (song4),
        .choice    (choice)
    );

    //////////////////////////////
    // processing
    //////////////////////////////

    songRom uSongRom (
        .choice (choice),
        .memLoc (memLoc),
        .entry  (entry)
    );

    noteSequencer uNoteSequencer (
        .playSound (playSound),
        .start     (start),
        .entry     (entry),
        .memLoc    (memLoc),
        .notecase  (notecase),
        .duration  (duration)
    );

    // output side, tone period
    pitchTable #(
        .clockHz (clockHz)
    ) uPitchTable (
        .notecase (notecase),
        .note     (note)
    );

endmodule

//--- hw/noteSequencer.sv
/*
 * note sequencer
 * walks the song table and registers pitch and duration per edge
 */
`timescale 1ns/100ps

module noteSequencer
    import musicBoxPkg::*;
(
    input  logic        playSound,
    input  logic        start,
    input  songEntry    entry,
    output songAddr     memLoc,
    output pitchCode    notecase,
    output noteDuration duration
);

    // entry fields, msb down
    logic        playFlag;
    pitchCode    entryPitch;
    noteDuration entryDur;

    assign playFlag   = entry[7];
    assign entryPitch = entry[6:2];
    assign entryDur   = entry[1:0];

    //////////////////////////////
    // address and note registers
    //////////////////////////////

    always_ff @(posedge playSound or posedge start) begin
        if (start) begin
            // rewind to the first note, silent meanwhile
            memLoc   <= firstNote;
            notecase <= restCode;
            duration <= '0;
        end
        else if (playFlag) begin
            // play it and step on
            notecase <= entryPitch;
            duration <= entryDur;
            memLoc   <= memLoc + 6'd1;
        end
        else begin
            // end of song, park on address 0
            // address 0 is always empty so the player idles there
            notecase <= restCode;
            duration <= '0;
            memLoc   <= '0;
        end
    end

endmodule

//--- hw/pitchTable.sv
/*
 * pitch to period lookup
 * half-period counts derived from the clock rate at elaboration
 */
`timescale 1ns/100ps

module pitchTable
    import musicBoxPkg::*;
#(
    parameter int clockHz = 100_000_000
) (
    input  pitchCode  notecase,
    output notePeriod note
);

    // semitones above C for the white keys, index 7 is the next C
    function automatic int whiteStep(input int idx);
        case (idx)
            0:       return 0;
            1:       return 2;
            2:       return 4;
            3:       return 5;
            4:       return 7;
            5:       return 9;
            6:       return 11;
            default: return 12;
        endcase
    endfunction

    // midi number of a code, -1 when silent
    function automatic int midiOf(input pitchCode code);
        if (code <= pitchB3) begin
            return 48 + whiteStep(int'(code - pitchC3));
        end
        if (code >= pitchC4 && code <= pitchB4) begin
            return 60 + whiteStep(int'(code - pitchC4));
        end
        if (code >= pitchC5 && code <= pitchC6) begin
            return 72 + whiteStep(int'(code - pitchC5));
        end
        // 7, rest and 24 up
        return -1;
    endfunction

    //////////////////////////////
    // elaboration-time table
    //////////////////////////////

    function automatic logic [31:0][19:0] buildTable();
        logic [31:0][19:0] t;
        int                midi;
        real               hz;
        for (int c = 0; c < 32; c++) begin
            midi = midiOf(pitchCode'(c));
            if (midi < 0) begin
                t[c] = '0;
            end
            else begin
                // equal temperament around A4 = 440 Hz
                hz   = 440.0 * (2.0 ** ((midi - 69) / 12.0));
                t[c] = notePeriod'($rtoi(real'(clockHz) / (2.0 * hz) + 0.5));
            end
        end
        return t;
    endfunction

    localparam logic [31:0][19:0] periods = buildTable();

    assign note = periods[notecase];

endmodule

//--- hw/songRom.sv
/*
 * melody ROM
 * returns the table entry for the chosen song at an address
 */
`timescale 1ns/100ps

module songRom
    import musicBoxPkg::*;
(
    input  songChoice choice,
    input  songAddr   memLoc,
    output songEntry  entry
);

    // pack a playable entry
    function automatic songEntry play(input pitchCode p, input noteDuration d);
        return {1'b1, p, d};
    endfunction

    //////////////////////////////
    // JAS, 47 notes
    //////////////////////////////

    function automatic songEntry jasEntry(input songAddr a);
        songEntry e;
        case (a)
            // first phrase
            6'd1:    e = play(pitchC4, 2'd1);
            6'd2:    e = play(pitchC4, 2'd0);
            6'd3:    e = play(pitchE4, 2'd0);
            6'd4:    e = play(pitchG4, 2'd1);
            6'd5:    e = play(pitchA4, 2'd1);
            6'd6:    e = play(pitchG4, 2'd3);
            6'd7:    e = play(pitchE4, 2'd1);
            // repeated
            6'd8:    e = play(pitchC4, 2'd1);
            6'd9:    e = play(pitchC4, 2'd0);
            6'd10:   e = play(pitchE4, 2'd0);
            6'd11:   e = play(pitchG4, 2'd1);
            6'd12:   e = play(pitchA4, 2'd1);
            6'd13:   e = play(pitchG4, 2'd3);
            6'd14:   e = play(pitchE4, 2'd1);
            6'd15:   e = play(pitchE4, 2'd1);
            6'd16:   e = play(pitchG4, 2'd1);
            6'd17:   e = play(pitchA4, 2'd1);
            6'd18:   e = play(pitchG4, 2'd1);
            6'd19:   e = play(pitchC5, 2'd1);
            6'd20:   e = play(pitchA4, 2'd1);
            6'd21:   e = play(pitchG4, 2'd2);
            6'd22:   e = play(pitchC4, 2'd1);
            6'd23:   e = play(pitchC4, 2'd0);
            6'd24:   e = play(pitchE4, 2'd0);
            6'd25:   e = play(pitchG4, 2'd1);
            6'd26:   e = play(pitchA4, 2'd1);
            6'd27:   e = play(pitchC5, 2'd1);
            6'd28:   e = play(pitchA4, 2'd1);
            6'd29:   e = play(pitchG4, 2'd2);
            // bridge
            6'd30:   e = play(pitchG4, 2'd1);
            6'd31:   e = play(pitchG4, 2'd1);
            6'd32:   e = play(pitchA4, 2'd2);
            6'd33:   e = play(pitchA4, 2'd0);
            6'd34:   e = play(pitchC5, 2'd1);
            6'd35:   e = play(pitchC5, 2'd0);
            6'd36:   e = play(pitchA4, 2'd0);
            6'd37:   e = play(pitchG4, 2'd2);
            // closing pair of bars
            6'd38:   e = play(pitchG4, 2'd1);
            6'd39:   e = play(pitchG4, 2'd0);
            6'd40:   e = play(pitchA4, 2'd0);
            6'd41:   e = play(pitchG4, 2'd2);
            6'd42:   e = play(pitchG4, 2'd2);
            6'd43:   e = play(pitchG4, 2'd1);
            6'd44:   e = play(pitchG4, 2'd0);
            6'd45:   e = play(pitchA4, 2'd0);
            6'd46:   e = play(pitchG4, 2'd2);
            6'd47:   e = play(pitchG4, 2'd2);
            // address 0 and past the end
            default: e = '0;
        endcase
        return e;
    endfunction

    //////////////////////////////
    // Old McDonald, 24 notes
    //////////////////////////////

    // one 12-note verse, played twice
    function automatic songEntry mcdEntry(input songAddr a);
        songAddr  idx;
        songEntry e;
        idx = (a > 6'd12) ? a - 6'd12 : a;
        case (idx)
            6'd1:    e = play(pitchC5, 2'd0);
            6'd2:    e = play(pitchC5, 2'd0);
            6'd3:    e = play(pitchC5, 2'd0);
            6'd4:    e = play(pitchG4, 2'd0);
            6'd5:    e = play(pitchA4, 2'd0);
            6'd6:    e = play(pitchA4, 2'd0);
            6'd7:    e = play(pitchG4, 2'd1);
            6'd8:    e = play(pitchE5, 2'd0);
            6'd9:    e = play(pitchE5, 2'd0);
            6'd10:   e = play(pitchD5, 2'd0);
            6'd11:   e = play(pitchD5, 2'd0);
            6'd12:   e = play(pitchC5, 2'd1);
            // address 0 and beyond the second verse
            default: e = '0;
        endcase
        return e;
    endfunction

    always_comb begin
        case (choice)
            songJas:      entry = jasEntry(memLoc);
            songMcDonald: entry = mcdEntry(memLoc);
            // nothing chosen reads as rest
            default:      entry = '0;
        endcase
    end

endmodule

//--- hw/songSelect.sv
/*
 * song selector
 * latches the last pressed song button into a held choice
 */
`timescale 1ns/100ps

module songSelect
    import musicBoxPkg::*;
(
    input  logic      playSound,
    input  logic      song3,
    input  logic      song4,
    output songChoice choice
);

    // held selection, nothing chosen at power-up
    songChoice held = songNone;

    //////////////////////////////
    // button sampling
    //////////////////////////////

    // not tied to start, a choice survives a restart
    always_ff @(posedge playSound) begin
        // song3 wins when both are down
        if (song3) begin
            held <= songJas;
        end
        else if (song4) begin
            held <= songMcDonald;
        end
        // no button, keep last choice
    end

    assign choice = held;

endmodule

//--- run.sh
#!/bin/sh
# build and run the music box testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module musicBoxTb -f files.f -o musicBoxSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/musicBoxSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim/musicBoxChecker.sv
/*
 * music box checker
 * models song choice and address from the score, compares every edge
 */
`timescale 1ns/100ps

module musicBoxChecker
    import musicBoxPkg::*;
#(
    parameter int clockHz = 100_000_000
) (
    input  logic        playSound,
    input  logic        start,
    input  logic        song3,
    input  logic        song4,
    input  notePeriod   note,
    input  noteDuration duration,
    input  songAddr     memLoc,
    input  pitchCode    notecase,
    output int          checks,
    output int          mismatches
);

    //////////////////////////////
    // score, pitch*10 + duration
    //////////////////////////////

    localparam int jasScore[47] = '{
        91, 90, 110, 131, 141, 133, 111, 91, 90, 110, 131, 141, 133, 111,
        111, 131, 141, 131, 161, 141, 132, 91, 90, 110, 131, 141,
        161, 141, 132, 131, 131, 142, 140, 161, 160, 140, 132,
        131, 130, 140, 132, 132, 131, 130, 140, 132, 132
    };
    // one verse, sung twice
    localparam int mcdScore[12] = '{
        160, 160, 160, 130, 140, 140, 131, 180, 180, 170, 170, 161
    };
    // semitones of the white keys above C, last one is the next C
    localparam int whiteKeys[8] = '{0, 2, 4, 5, 7, 9, 11, 12};

    songChoice   modelChoice = songNone;
    songAddr     modelAddr;
    pitchCode    expCase;
    noteDuration expDur;
    logic        modelValid = 1'b0;
    logic [7:0]  nextEntry;
    int          checkCount = 0;
    int          errorCount = 0;

    assign checks     = checkCount;
    assign mismatches = errorCount;

    // reference: {play, pitch, duration} at a song position
    function automatic logic [7:0] scoreEntry(input songChoice song, input songAddr addr);
        int pos;
        int code;
        pos  = int'(addr) - 1;
        code = -1;
        if (song == songJas && pos >= 0 && pos < 47) begin
            code = jasScore[pos];
        end
        if (song == songMcDonald && pos >= 0 && pos < 24) begin
            code = mcdScore[pos % 12];
        end
        if (code < 0) begin
            return 8'h00;
        end
        return {1'b1, pitchCode'(code / 10), noteDuration'(code % 10)};
    endfunction

    // half period from equal temperament, 0 when silent
    function automatic notePeriod periodOf(input pitchCode code);
        int  c;
        int  midi;
        real hz;
        c = int'(code);
        if (c <= 6) begin
            midi = 48 + whiteKeys[c];
        end
        else if (c >= 9 && c <= 15) begin
            midi = 60 + whiteKeys[c - 9];
        end
        else if (c >= 16 && c <= 23) begin
            midi = 72 + whiteKeys[c - 16];
        end
        else begin
            return '0;
        end
        hz = 440.0 * (2.0 ** (real'(midi - 69) / 12.0));
        return notePeriod'($rtoi(real'(clockHz) / (2.0 * hz) + 0.5));
    endfunction

    // buttons latch on the edge, song3 first
    always @(posedge playSound) begin
        if (song3) begin
            modelChoice <= songJas;
        end
        else if (song4) begin
            modelChoice <= songMcDonald;
        end
    end

    always @(posedge playSound or posedge start) begin
        if (start) begin
            modelAddr  <= firstNote;
            expCase    <= restCode;
            expDur     <= '0;
            modelValid <= 1'b1;
        end
        else begin
            nextEntry = scoreEntry(modelChoice, modelAddr);
            if (nextEntry[7]) begin
                expCase   <= nextEntry[6:2];
                expDur    <= nextEntry[1:0];
                modelAddr <= modelAddr + 6'd1;
            end
            else begin
                // end of song, idle on 0
                expCase   <= restCode;
                expDur    <= '0;
                modelAddr <= '0;
            end
        end
    end

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        errorCount++;
        $display("[FAIL] t=%0d ns: %s is %0d, expected %0d", $time, what, got, want);
    endtask

    //////////////////////////////
    // compare mid-cycle
    //////////////////////////////

    always @(negedge playSound) begin
        if (modelValid) begin
            checkCount++;
            if (memLoc !== modelAddr) begin
                reportMismatch("memLoc", 32'(memLoc), 32'(modelAddr));
            end
            if (notecase !== expCase) begin
                reportMismatch("notecase", 32'(notecase), 32'(expCase));
            end
            if (duration !== expDur) begin
                reportMismatch("duration", 32'(duration), 32'(expDur));
            end
            if (note !== periodOf(expCase)) begin
                reportMismatch("note", 32'(note), 32'(periodOf(expCase)));
            end
        end
    end

endmodule

//--- sim/musicBoxTb.sv
/*
 * music box testbench
 * clock, reset, song scenarios and run limit around the player
 */
`timescale 1ns/100ps

module musicBoxTb
    import musicBoxPkg::*;
();

    localparam int clockHz = 100_000_000;
    // six scenarios of at most 60 cycles, plus margin
    localparam int scenarioCycles = 60;
    localparam int maxCycles = 6 * scenarioCycles + 40;

    logic        playSound;
    logic        start;
    logic        song3;
    logic        song4;
    notePeriod   note;
    noteDuration duration;
    songAddr     memLoc;
    pitchCode    notecase;

    int checks;
    int mismatches;
    int stalls = 0;
    int cycles = 0;
    integer seed;

    musicBoxTop #(
        .clockHz (clockHz)
    ) DUT (
        .playSound (playSound),
        .start     (start),
        .song3     (song3),
        .song4     (song4),
        .note      (note),
        .duration  (duration),
        .memLoc    (memLoc),
        .notecase  (notecase)
    );

    musicBoxChecker #(
        .clockHz (clockHz)
    ) uChecker (
        .playSound  (playSound),
        .start      (start),
        .song3      (song3),
        .song4      (song4),
        .note       (note),
        .duration   (duration),
        .memLoc     (memLoc),
        .notecase   (notecase),
        .checks     (checks),
        .mismatches (mismatches)
    );

    // sequencer rules ride along inside the DUT
    bind noteSequencer musicBoxProps uProps (
        .playSound (playSound),
        .start     (start),
        .memLoc    (memLoc),
        .notecase  (notecase),
        .duration  (duration)
    );

    // 8 ns period
    initial begin
        playSound = 1'b0;
        forever #4 playSound = ~playSound;
    end

    //////////////////////////////
    // run limit
    //////////////////////////////

    always @(posedge playSound) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("Verification failed");
            $finish;
        end
    end

    // one button press, held for a single edge
    task automatic pressButtons(input logic s3, input logic s4);
        @(posedge playSound);
        song3 <= s3;
        song4 <= s4;
        @(posedge playSound);
        song3 <= 1'b0;
        song4 <= 1'b0;
    endtask

    // pulse start for two edges
    task automatic restartSong();
        @(posedge playSound);
        start <= 1'b1;
        repeat (2) @(posedge playSound);
        start <= 1'b0;
    endtask

    // done means the address parked back on 0
    task automatic waitIdle();
        int n;
        n = 0;
        @(negedge playSound);
        while (memLoc !== '0 && n < scenarioCycles) begin
            @(negedge playSound);
            n++;
        end
        if (memLoc !== '0) begin
            stalls++;
            $display("player did not return to idle within %0d cycles", scenarioCycles);
        end
    endtask

    // idle stretch of 1 to 8 edges between scenarios
    task automatic randomGap();
        int n;
        n = 1 + ($random(seed) & 7);
        repeat (n) @(posedge playSound);
    endtask

    initial begin
        int propFails;
        seed  = 32'h5e9e;
        start = 1'b1;
        song3 = 1'b0;
        song4 = 1'b0;
        repeat (16) @(posedge playSound);
        start <= 1'b0;

        // nothing chosen yet, player idles
        waitIdle();
        repeat (4) @(posedge playSound);
        randomGap();

        // JAS from the top
        pressButtons(1'b1, 1'b0);
        restartSong();
        waitIdle();
        randomGap();

        // McDonald after JAS, no leftovers past note 24
        pressButtons(1'b0, 1'b1);
        restartSong();
        waitIdle();
        randomGap();

        // both buttons, song3 wins
        pressButtons(1'b1, 1'b1);
        restartSong();
        waitIdle();
        randomGap();

        // restart partway through
        pressButtons(1'b1, 1'b0);
        restartSong();
        repeat (12) @(posedge playSound);
        restartSong();
        waitIdle();

        repeat (2) @(posedge playSound);
        @(negedge playSound);
        propFails = DUT.uNoteSequencer.uProps.violations;
        $display("checks %0d, mismatches %0d, stalls %0d, assertion failures %0d",
                 checks, mismatches, stalls, propFails);
        if (mismatches == 0 && stalls == 0 && propFails == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/musicBox_props.sv
/*
 * sequencer properties
 * rest shape, idle hold and legal pitch codes
 */
`timescale 1ns/100ps

module musicBoxProps
    import musicBoxPkg::*;
(
    input logic        playSound,
    input logic        start,
    input songAddr     memLoc,
    input pitchCode    notecase,
    input noteDuration duration
);

    // failures seen so far
    int violations = 0;

    // a rest never carries a length
    restSilent: assert property (@(posedge playSound) disable iff (start)
        notecase == restCode |-> duration == '0)
        else begin
            violations++;
            $error("rest shown with nonzero duration");
        end

    // idle slot is sticky until start
    idleHold: assert property (@(posedge playSound) disable iff (start)
        memLoc == '0 |=> memLoc == '0)
        else begin
            violations++;
            $error("player left address 0 without start");
        end

    // no gap code and nothing above C6
    legalPitch: assert property (@(posedge playSound) disable iff (start)
        notecase != 5'd7 && notecase <= pitchC6)
        else begin
            violations++;
            $error("illegal pitch code on notecase");
        end

endmodule
